// File: filelist.f
hdl/rename_cfg_pkg.sv
hdl/rename_if_pkg.sv
hdl/free_list.sv
hdl/map_table.sv
hdl/rename_stage.sv
hdl/rename_top.sv
verification/rename_props.sv
verification/rename_tb.sv

// File: hdl/free_list.sv
`timescale 1ns/1ps

// Free physical registers kept as a circular queue
// Head side hands registers out, tail side takes them back
module free_list
  import rename_cfg_pkg::*, rename_if_pkg::*;
#(
  parameter int NUM_PHYS_REGS = 64,
  parameter int NUM_ARCH_REGS = 32
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [1:0]                   acquire_num,  // Registers taken at head
  input  release_t                     rel,          // Registers returned at tail
  output phys_reg_t [RENAME_WIDTH-1:0] head_regs,    // Next two in queue order
  output free_count_t                  count         // Occupied entries
);

  // Every register above the architectural ones can be free at once
  localparam int DEPTH    = NUM_PHYS_REGS - NUM_ARCH_REGS;
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_BITS-1:0] ptr_t;

  phys_reg_t  mem [DEPTH];  // Queue storage
  ptr_t       head;         // Oldest free register
  ptr_t       tail;         // Next slot to write on release
  ptr_t       head_plus1;
  ptr_t       rel1_ptr;     // Write slot for release slot 1
  logic [1:0] rel_num;      // Registers returned this cycle

  // Pointer advance with wrap, depth need not be a power of two
  function automatic ptr_t ptr_add(input ptr_t ptr, input logic [1:0] inc);
    logic [PTR_BITS:0] sum;
    sum = {1'b0, ptr} + (PTR_BITS+1)'(inc);
    if (sum >= (PTR_BITS+1)'(DEPTH)) begin
      sum = sum - (PTR_BITS+1)'(DEPTH);
    end
    return sum[PTR_BITS-1:0];
  endfunction

  assign head_plus1 = ptr_add(head, 2'd1);

  // Only reads, count tells the consumer how many are real
  assign head_regs[0] = mem[head];
  assign head_regs[1] = mem[head_plus1];

  assign rel_num = {1'b0, rel[0].valid} + {1'b0, rel[1].valid};

  // Slot 1 packs behind slot 0, or takes the tail itself if slot 0 is idle
  assign rel1_ptr = rel[0].valid ? ptr_add(tail, 2'd1) : tail;

  // Queue contents
  // Starts as NUM_ARCH_REGS up to NUM_PHYS_REGS-1, lowest at head
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= phys_reg_t'(NUM_ARCH_REGS + i);
      end
    end else begin
      if (rel[0].valid) begin
        mem[tail] <= rel[0].preg;
      end
      if (rel[1].valid) begin
        mem[rel1_ptr] <= rel[1].preg;  // Never collides with slot 0 write
      end
    end
  end

  // Pointers and occupancy
  // A register written at tail now is visible at head from the next cycle on
  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;                    // Full queue, tail wrapped onto head
      count <= free_count_t'(DEPTH);
    end else begin
      head  <= ptr_add(head, acquire_num);
      tail  <= ptr_add(tail, rel_num);
      count <= count + free_count_t'(rel_num) - free_count_t'(acquire_num);
    end
  end

endmodule : free_list

// File: hdl/map_table.sv
`timescale 1ns/1ps

// Architectural to physical register map
// Reads are combinational, writes land at the clock edge
module map_table
  import rename_cfg_pkg::*, rename_if_pkg::*;
#(
  parameter int NUM_PHYS_REGS = 64,
  parameter int NUM_ARCH_REGS = 32
) (
  input  logic                              clk,
  input  logic                              rst,
  input  rename_req_t                       req,
  input  phys_reg_t [RENAME_WIDTH-1:0]      new_dest,  // From rename_stage
  input  logic [1:0]                        write_en,  // Per slot, on accept
  output phys_reg_t [RENAME_WIDTH-1:0][1:0] src_phys,  // [slot][src1, src2]
  output phys_reg_t [RENAME_WIDTH-1:0]      old_phys   // Mapping being replaced
);

  // Entries only need enough bits for the configured register file
  localparam int MAP_BITS = $clog2(NUM_PHYS_REGS);

  typedef logic [MAP_BITS-1:0] map_entry_t;

  map_entry_t map_q [NUM_ARCH_REGS];

  logic slot0_writes;  // Slot 0 claims a new destination
  logic fwd_src1;      // Slot 1 operands that must see slot 0's result
  logic fwd_src2;
  logic fwd_dest;

  assign slot0_writes = req[0].valid & req[0].has_dest;

  assign fwd_src1 = slot0_writes && (req[0].dest == req[1].src1);
  assign fwd_src2 = slot0_writes && (req[0].dest == req[1].src2);
  assign fwd_dest = slot0_writes && (req[0].dest == req[1].dest);

  always_comb begin
    // Plain table lookups for both slots
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      src_phys[s][0] = phys_reg_t'(map_q[req[s].src1]);
      src_phys[s][1] = phys_reg_t'(map_q[req[s].src2]);
      old_phys[s]    = phys_reg_t'(map_q[req[s].dest]);
    end

    // Slot 1 is younger, table is still one write behind for it
    if (fwd_src1) begin
      src_phys[1][0] = new_dest[0];
    end
    if (fwd_src2) begin
      src_phys[1][1] = new_dest[0];
    end
    if (fwd_dest) begin
      old_phys[1] = new_dest[0];  // Slot 1 frees what slot 0 just took
    end
  end

  // Identity map after reset, slot 1 is written last and wins a collision
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        map_q[i] <= map_entry_t'(i);
      end
    end else begin
      for (int s = 0; s < RENAME_WIDTH; s++) begin
        if (write_en[s]) begin
          map_q[req[s].dest] <= new_dest[s][MAP_BITS-1:0];
        end
      end
    end
  end

endmodule : map_table

// File: hdl/rename_cfg_pkg.sv
package rename_cfg_pkg;

  // Group size, slot forwarding in map_table is written for exactly two
  localparam int RENAME_WIDTH = 2;

  localparam int ARCH_REG_BITS = 5;  // 32 architectural registers
  localparam int PHYS_REG_BITS = 7;  // Up to 128 physical registers
  localparam int FREE_CNT_BITS = 8;  // Holds 0..128 inclusive

  // Architectural register number as seen by the decoder
  typedef logic [ARCH_REG_BITS-1:0] arch_reg_t;

  // Physical register number, index into the register file
  typedef logic [PHYS_REG_BITS-1:0] phys_reg_t;

  // Number of free list entries currently holding a register
  typedef logic [FREE_CNT_BITS-1:0] free_count_t;

endpackage : rename_cfg_pkg

// File: hdl/rename_if_pkg.sv
package rename_if_pkg;

  import rename_cfg_pkg::*;

  // One instruction as it arrives from decode
  typedef struct packed {
    logic      valid;     // Slot carries an instruction
    logic      has_dest;  // Instruction writes a register
    arch_reg_t dest;
    arch_reg_t src1;
    arch_reg_t src2;
  } rename_slot_t;

  // Slot 0 is the older instruction of the group
  typedef rename_slot_t [RENAME_WIDTH-1:0] rename_req_t;

  // One instruction after renaming
  typedef struct packed {
    logic      valid;
    logic      has_dest;
    phys_reg_t new_dest;  // Register taken from the free list
    phys_reg_t old_dest;  // Previous mapping, freed at commit
    phys_reg_t src1;
    phys_reg_t src2;
  } renamed_slot_t;

  typedef renamed_slot_t [RENAME_WIDTH-1:0] renamed_grp_t;

  // Commit side return of a previous destination
  typedef struct packed {
    logic      valid;
    phys_reg_t preg;
  } release_slot_t;

  // Slot 0 is appended to the queue first
  typedef release_slot_t [RENAME_WIDTH-1:0] release_t;

endpackage : rename_if_pkg

// File: hdl/rename_stage.sv
`timescale 1ns/1ps

// Rename control
// Checks register supply, assigns free registers, registers the result
module rename_stage
  import rename_cfg_pkg::*, rename_if_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst,
  input  rename_req_t                       req,
  input  logic                              req_valid,
  input  phys_reg_t [RENAME_WIDTH-1:0]      head_regs,    // Free list head
  input  free_count_t                       count,        // Free list occupancy
  input  phys_reg_t [RENAME_WIDTH-1:0][1:0] src_phys,     // Map table reads
  input  phys_reg_t [RENAME_WIDTH-1:0]      old_phys,
  output logic                              stall,        // Too few registers
  output logic [1:0]                        acquire_num,  // Pops from free list
  output phys_reg_t [RENAME_WIDTH-1:0]      new_dest,     // Per slot assignment
  output logic [1:0]                        write_en,     // Map table writes
  output renamed_grp_t                      out,
  output logic                              out_valid
);

  logic [RENAME_WIDTH-1:0] need_dest;  // Slot needs a fresh register
  logic [1:0]              need;       // Registers the group asks for
  logic                    accept;
  renamed_grp_t            grp_d;      // Result before the output register

  always_comb begin
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      need_dest[s] = req[s].valid & req[s].has_dest;
    end
  end

  assign need = {1'b0, need_dest[0]} + {1'b0, need_dest[1]};

  // Depends on request and supply only, not on req_valid
  assign stall  = free_count_t'(need) > count;
  assign accept = req_valid & ~stall;

  // Slot 1 takes the first head register if slot 0 did not use it
  assign new_dest[0] = head_regs[0];
  assign new_dest[1] = need_dest[0] ? head_regs[1] : head_regs[0];

  assign acquire_num = accept ? need : 2'd0;
  assign write_en    = accept ? need_dest : 2'b00;

  always_comb begin
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      grp_d[s] = '0;  // Invalid slots come out all zero
      if (req[s].valid) begin
        grp_d[s].valid    = 1'b1;
        grp_d[s].has_dest = req[s].has_dest;
        grp_d[s].src1     = src_phys[s][0];
        grp_d[s].src2     = src_phys[s][1];
        if (req[s].has_dest) begin
          grp_d[s].new_dest = new_dest[s];
          grp_d[s].old_dest = old_phys[s];
        end
      end
    end
  end

  // Payload only moves on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      out <= grp_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= accept;  // One cycle per accepted group
    end
  end

endmodule : rename_stage

// File: hdl/rename_top.sv
`timescale 1ns/1ps

// Register rename block, two instructions per cycle
module rename_top
  import rename_cfg_pkg::*, rename_if_pkg::*;
#(
  parameter int NUM_PHYS_REGS = 64,
  parameter int NUM_ARCH_REGS = 32
) (
  input  logic         clk,
  input  logic         rst,
  input  rename_req_t  req,
  input  logic         req_valid,
  input  release_t     rel,        // Commit returns, always taken
  output logic         stall,
  output renamed_grp_t out,
  output logic         out_valid
);

  logic [1:0]                        acquire_num;
  phys_reg_t [RENAME_WIDTH-1:0]      head_regs;
  free_count_t                       count;
  phys_reg_t [RENAME_WIDTH-1:0][1:0] src_phys;
  phys_reg_t [RENAME_WIDTH-1:0]      old_phys;
  phys_reg_t [RENAME_WIDTH-1:0]      new_dest;
  logic [1:0]                        write_en;

  free_list #(
    .NUM_PHYS_REGS(NUM_PHYS_REGS),
    .NUM_ARCH_REGS(NUM_ARCH_REGS)
  ) i_free_list (
    .clk        (clk),
    .rst        (rst),
    .acquire_num(acquire_num),
    .rel        (rel),
    .head_regs  (head_regs),
    .count      (count)
  );

  map_table #(
    .NUM_PHYS_REGS(NUM_PHYS_REGS),
    .NUM_ARCH_REGS(NUM_ARCH_REGS)
  ) i_map_table (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .new_dest(new_dest),
    .write_en(write_en),
    .src_phys(src_phys),
    .old_phys(old_phys)
  );

  rename_stage i_rename_stage (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .req_valid  (req_valid),
    .head_regs  (head_regs),
    .count      (count),
    .src_phys   (src_phys),
    .old_phys   (old_phys),
    .stall      (stall),
    .acquire_num(acquire_num),
    .new_dest   (new_dest),
    .write_en   (write_en),
    .out        (out),
    .out_valid  (out_valid)
  );

endmodule : rename_top

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the rename testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module rename_tb -o rename_sim \
  && ./obj_dir/rename_sim 2>&1 | tee sim.log \
  || { echo "Verilator build or simulation run failed"; exit 1; }
grep -q "Simulation finished: FAIL" sim.log && { echo "Testbench reported failure"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "No verdict in sim.log"; exit 1; }
exit 0

// File: verification/rename_props.sv
`timescale 1ns/1ps

// Occupancy and reset assertions bound into free_list and rename_stage
module rename_props
  import rename_cfg_pkg::*;
#(
  parameter int CAPACITY = 128  // Free list depth
) (
  input logic        clk,
  input logic        rst,
  input free_count_t count,
  input logic [1:0]  acquire_num,
  input logic        out_valid
);

  count_in_range: assert property (
    @(posedge clk) disable iff (rst) count <= free_count_t'(CAPACITY)
  ) else $error("free list count %0d above capacity %0d", count, CAPACITY);

  // Never pop more than the queue holds
  acquire_covered: assert property (
    @(posedge clk) disable iff (rst) free_count_t'(acquire_num) <= count
  ) else $error("acquire_num %0d with only %0d free", acquire_num, count);

  out_idle_after_reset: assert property (
    @(posedge clk) rst |=> !out_valid
  ) else $error("out_valid high in the cycle after reset");

endmodule : rename_props

bind free_list rename_props #(
  .CAPACITY(NUM_PHYS_REGS - NUM_ARCH_REGS)
) i_free_list_props (
  .clk        (clk),
  .rst        (rst),
  .count      (count),
  .acquire_num(acquire_num),
  .out_valid  (1'b0)  // Free list has no output stage
);

bind rename_stage rename_props i_rename_stage_props (
  .clk        (clk),
  .rst        (rst),
  .count      (count),
  .acquire_num(acquire_num),
  .out_valid  (out_valid)
);

// File: verification/rename_tb.sv
`timescale 1ns/1ps

// Testbench for the two-wide register rename block
module rename_tb
  import rename_cfg_pkg::*, rename_if_pkg::*;
();

  localparam int NUM_PHYS_REGS = 64;
  localparam int NUM_ARCH_REGS = 32;
  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 5;
  localparam int NUM_RANDOM    = 12;  // Two destinations each, drains the initial supply
  localparam int MAX_REPEAT    = 6;   // Cycles a stalled row may repeat
  localparam int OUT_TIMEOUT   = 4;   // Cycles to wait for out_valid
  localparam logic [31:0] SEED = 32'h4b08_418e;

  // One table row, applied once or repeated while stalled
  typedef struct packed {
    rename_req_t req;
    logic        req_valid;
    release_t    rel;
  } stim_row_t;

  logic         clk = 1'b0;
  logic         rst;
  rename_req_t  req;
  logic         req_valid;
  release_t     rel;
  logic         stall;
  renamed_grp_t out;
  logic         out_valid;

  stim_row_t rows [$];                 // Stimulus table
  phys_reg_t ref_map [NUM_ARCH_REGS];  // Model of the map
  phys_reg_t ref_free [$];             // Model of the free queue, head first
  int        grp_errors;
  int        bit_errors;
  int        timeouts;

  always #(CLK_PERIOD/2) clk = ~clk;

  rename_top #(
    .NUM_PHYS_REGS(NUM_PHYS_REGS),
    .NUM_ARCH_REGS(NUM_ARCH_REGS)
  ) i_rename_top (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .req_valid(req_valid),
    .rel      (rel),
    .stall    (stall),
    .out      (out),
    .out_valid(out_valid)
  );

  function automatic rename_slot_t make_slot(input int valid, input int has_dest,
                                             input int dest, input int src1, input int src2);
    rename_slot_t s;
    s.valid    = 1'(valid);
    s.has_dest = 1'(has_dest);
    s.dest     = arch_reg_t'(dest);
    s.src1     = arch_reg_t'(src1);
    s.src2     = arch_reg_t'(src2);
    return s;
  endfunction

  function automatic rename_slot_t random_slot();
    int d;
    int a;
    int b;
    d = $urandom % NUM_ARCH_REGS;
    a = $urandom % NUM_ARCH_REGS;
    b = $urandom % NUM_ARCH_REGS;
    return make_slot(1, 1, d, a, b);
  endfunction

  function automatic release_t make_rel(input int v0, input int p0, input int v1, input int p1);
    release_t r;
    r[0].valid = 1'(v0);
    r[0].preg  = phys_reg_t'(p0);
    r[1].valid = 1'(v1);
    r[1].preg  = phys_reg_t'(p1);
    return r;
  endfunction

  task automatic add_row(input rename_slot_t s0, input rename_slot_t s1,
                         input logic vld, input release_t r);
    stim_row_t row;
    row.req[0]    = s0;
    row.req[1]    = s1;
    row.req_valid = vld;
    row.rel       = r;
    rows.push_back(row);
  endtask

  task automatic build_table();
    add_row(make_slot(1, 1, 1, 2, 3), make_slot(1, 1, 4, 5, 6), 1'b1, '0);    // Gets 32, 33
    add_row(make_slot(1, 1, 7, 8, 9), make_slot(1, 1, 10, 7, 11), 1'b1, '0);  // Src forward
    add_row(make_slot(1, 1, 12, 1, 4), make_slot(1, 1, 12, 12, 7), 1'b1, '0); // Same dest
    add_row(make_slot(1, 0, 0, 12, 4), make_slot(0, 1, 20, 1, 2), 1'b1, '0);  // Reads 12
    add_row(make_slot(1, 0, 3, 1, 7), make_slot(1, 1, 13, 10, 2), 1'b1, '0);
    add_row(make_slot(0, 1, 5, 6, 7), make_slot(1, 1, 14, 13, 12), 1'b1, '0);
    add_row(make_slot(1, 1, 9, 9, 9), make_slot(1, 1, 8, 8, 8), 1'b0, '0);    // Not offered
    for (int i = 0; i < NUM_RANDOM; i++) begin
      add_row(random_slot(), random_slot(), 1'b1, '0);
    end
    // Supply is empty here, each row's own releases let it through a cycle later
    add_row(make_slot(1, 1, 2, 1, 3), make_slot(1, 1, 3, 2, 4), 1'b1, make_rel(1, 1, 1, 4));
    add_row(make_slot(1, 1, 5, 2, 3), make_slot(0, 0, 0, 0, 0), 1'b1, make_rel(0, 0, 1, 7));
    add_row(make_slot(1, 1, 6, 5, 5), make_slot(1, 1, 8, 6, 6), 1'b1, make_rel(1, 10, 1, 12));
    add_row(make_slot(1, 1, 9, 8, 1), make_slot(0, 0, 0, 0, 0), 1'b1, make_rel(1, 13, 1, 14));
    // 14 goes out while 36 is queued behind it
    add_row(make_slot(1, 1, 11, 9, 9), make_slot(0, 0, 0, 0, 0), 1'b1, make_rel(1, 36, 0, 0));
    add_row(make_slot(1, 0, 0, 11, 2), make_slot(1, 1, 15, 11, 3), 1'b1, '0);  // Gets 36
  endtask

  // Stall when the group asks for more than the model queue holds
  function automatic logic expect_stall(input rename_req_t r);
    int need;
    need = 0;
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      if (r[s].valid && r[s].has_dest) begin
        need++;
      end
    end
    return need > ref_free.size();
  endfunction

  // Renames slot by slot against a working copy, so slot 1 sees slot 0's update
  task automatic model_step(input stim_row_t row, input logic accepted,
                            output renamed_grp_t grp);
    phys_reg_t lmap [NUM_ARCH_REGS];
    lmap = ref_map;
    grp  = '0;
    if (accepted) begin
      for (int s = 0; s < RENAME_WIDTH; s++) begin
        if (row.req[s].valid) begin
          grp[s].valid    = 1'b1;
          grp[s].has_dest = row.req[s].has_dest;
          grp[s].src1     = lmap[row.req[s].src1];
          grp[s].src2     = lmap[row.req[s].src2];
          if (row.req[s].has_dest) begin
            grp[s].new_dest = ref_free.pop_front();
            grp[s].old_dest = lmap[row.req[s].dest];
            lmap[row.req[s].dest] = grp[s].new_dest;
          end
        end
      end
      ref_map = lmap;
    end
    // Returns join the tail after this cycle's hand-out
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      if (row.rel[s].valid) begin
        ref_free.push_back(row.rel[s].preg);
      end
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      bit_errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_grp(input renamed_grp_t got, input renamed_grp_t exp, input string what);
    if (got !== exp) begin
      grp_errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Result is due at this falling edge, later is a timing error
  task automatic wait_out_valid(output logic seen);
    int cycles;
    cycles = 0;
    while (!out_valid && cycles < OUT_TIMEOUT) begin
      req_valid = 1'b0;  // No new groups while waiting
      rel       = '0;
      @(negedge clk);
      cycles++;
    end
    seen = out_valid;
    if (!seen) begin
      timeouts++;
      $display("Timeout: out_valid did not rise within %0d cycles of an accept", OUT_TIMEOUT);
    end else if (cycles != 0) begin
      bit_errors++;
      $display("Error at %0t ns: out_valid came %0d cycles late", $time, cycles);
    end
  endtask

  task automatic check_result(input logic due, input renamed_grp_t exp, input int idx);
    logic seen;
    if (due) begin
      wait_out_valid(seen);
      if (seen) begin
        check_grp(out, exp, $sformatf("group of row %0d", idx));
      end
    end else begin
      check_bit(out_valid, 1'b0, "out_valid");
    end
  endtask

  initial begin : main
    stim_row_t    row;
    renamed_grp_t exp_grp;
    logic         pending;    // Accepted group, result due next
    logic         exp_stall;
    int           acc_row;
    int           repeats;
    void'($urandom(SEED));
    rst        = 1'b1;
    req        = '0;
    req_valid  = 1'b0;
    rel        = '0;
    grp_errors = 0;
    bit_errors = 0;
    timeouts   = 0;
    pending    = 1'b0;
    exp_grp    = '0;
    acc_row    = 0;
    for (int i = 0; i < NUM_ARCH_REGS; i++) begin
      ref_map[i] = phys_reg_t'(i);  // Identity map
    end
    for (int i = NUM_ARCH_REGS; i < NUM_PHYS_REGS; i++) begin
      ref_free.push_back(phys_reg_t'(i));
    end
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (rows[i]) begin
      row     = rows[i];
      repeats = 0;
      do begin
        check_result(pending, exp_grp, acc_row);
        req       = row.req;
        req_valid = row.req_valid;
        rel       = row.rel;
        #(CLK_PERIOD/4);
        exp_stall = expect_stall(row.req);
        check_bit(stall, exp_stall, $sformatf("stall of row %0d", i));
        pending = row.req_valid && !exp_stall;
        model_step(row, pending, exp_grp);
        acc_row = i;
        row.rel = '0;  // Returns go in once, a repeated row carries none
        repeats++;
        @(negedge clk);
      end while (row.req_valid && exp_stall && repeats < MAX_REPEAT);
      if (row.req_valid && exp_stall) begin
        timeouts++;
        $display("Timeout: row %0d still stalled after %0d cycles", i, MAX_REPEAT);
      end
    end
    check_result(pending, exp_grp, acc_row);
    req_valid = 1'b0;
    rel       = '0;
    @(negedge clk);
    check_result(1'b0, exp_grp, acc_row);
    $display("Errors: %0d group, %0d flag, %0d timeout", grp_errors, bit_errors, timeouts);
    if (grp_errors + bit_errors + timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : rename_tb
